//--- Makefile
TOP = tb_palette_dac_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f palette_dac.f
	obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^all tests passed$$"

clean:
	rm -rf obj_dir

//--- palette_dac.f
src/palette_pkg.sv
src/palette_regs_pkg.sv
src/palette_ram.sv
src/palette_ctrl_regs.sv
src/layer_mixer.sv
src/color_palette_dac.sv
src/palette_dac_top.sv
testbench/palette_dac_properties.sv
testbench/tb_palette_dac_top.sv

//--- src/color_palette_dac.sv
`timescale 1ns/1ps

// Palette RAM with CPU access and RGB555 output
module color_palette_dac #(
	parameter int CODE_BITS = 7,
	parameter int BANK_BITS = 4
) (
	input  logic                              CLK,
	input  logic                              reset,
	input  logic [CODE_BITS-1:0]              pix_code,
	input  logic [BANK_BITS-1:0]              pix_bank,
	input  logic                              disp_d1,
	input  logic                              disp_en,
	input  logic [BANK_BITS+7:0]              cpu_addr,
	input  logic [7:0]                        cpu_din,
	input  logic                              cpu_rw,     // 1 means write
	input  logic                              pal_cs_n,
	input  logic                              pal_wr_n,
	output logic [7:0]                        pal_dout,
	output logic [palette_pkg::COLOR_W-1:0]   red,
	output logic [palette_pkg::COLOR_W-1:0]   green,
	output logic [palette_pkg::COLOR_W-1:0]   blue
);

	localparam int PAL_AW = CODE_BITS + BANK_BITS;

	logic [PAL_AW-1:0]          pal_addr;
	logic                       cpu_sel;    // CPU owns the palette
	logic                       lo_cs;
	logic                       hi_cs;
	logic                       lo_we;
	logic                       hi_we;
	logic [7:0]                 q_lo;
	logic [7:0]                 q_hi;
	logic                       disp_d2;
	palette_pkg::palette_entry_u pal_word;

	// ==============================
	// Address and byte enables
	// ==============================
	// Display side drives the address while disp_en is high
	assign pal_addr = disp_en ? {pix_bank, pix_code}
	                          : {cpu_addr[BANK_BITS+7:8], cpu_addr[CODE_BITS:1]};

	assign cpu_sel = ~pal_cs_n & ~disp_en;   // Accesses during display are dropped
	assign lo_cs   = cpu_sel & cpu_addr[0];  // A0 inverted on the byte select
	assign hi_cs   = cpu_sel & ~cpu_addr[0];
	assign lo_we   = lo_cs & ~pal_wr_n & cpu_rw;
	assign hi_we   = hi_cs & ~pal_wr_n & cpu_rw;

	palette_ram #(.ADDR_W(PAL_AW)) i_pal_ram_lo (
		.CLK  (CLK),
		.addr (pal_addr),
		.data (cpu_din),
		.we   (lo_we),
		.q    (q_lo)
	);

	palette_ram #(.ADDR_W(PAL_AW)) i_pal_ram_hi (
		.CLK  (CLK),
		.addr (pal_addr),
		.data (cpu_din),
		.we   (hi_we),
		.q    (q_hi)
	);

	// Open bus reads as all ones
	assign pal_dout = (lo_cs & ~cpu_rw) ? q_lo :
	                  (hi_cs & ~cpu_rw) ? q_hi :
	                  8'hFF;

	// ==============================
	// RGB decode and blanking
	// ==============================
	always_comb begin
		pal_word.bytes.hi = q_hi;
		pal_word.bytes.lo = q_lo;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			disp_d2 <= 1'b0;
			red     <= '0;
			green   <= '0;
			blue    <= '0;
		end else begin
			disp_d2 <= disp_d1;               // Lines up with RAM read data
			if (disp_d2) begin
				red   <= pal_word.color.r;
				green <= {pal_word.color.g_hi, pal_word.color.g_lo};
				blue  <= pal_word.color.b;
			end else begin
				red   <= '0;                  // Black outside active video
				green <= '0;
				blue  <= '0;
			end
		end
	end

endmodule

//--- src/layer_mixer.sv
`timescale 1ns/1ps

// Picks one colour code and bank per pixel from the two layers
module layer_mixer #(
	parameter int CODE_BITS = 7,
	parameter int BANK_BITS = 4
) (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic [CODE_BITS-1:0] fg_code,
	input  logic [CODE_BITS-1:0] bg_code,
	input  logic                 disp_en,
	input  logic [BANK_BITS-1:0] fg_bank,
	input  logic [BANK_BITS-1:0] bg_bank,
	input  logic                 fg_en,
	input  logic                 bg_en,
	input  logic                 bg_prio,
	output logic [CODE_BITS-1:0] pix_code,
	output logic [BANK_BITS-1:0] pix_bank,
	output logic                 disp_d1
);

	logic fg_opaque;
	logic bg_opaque;
	logic pick_fg;
	logic pick_bg;

	// Pen 0 of every 16 colour group is transparent
	assign fg_opaque = fg_en & (|fg_code[3:0]);
	assign bg_opaque = bg_en & (|bg_code[3:0]);

	// Foreground wins unless background is opaque and has priority
	assign pick_fg = fg_opaque & (~bg_opaque | ~bg_prio);
	assign pick_bg = bg_opaque & ~pick_fg;

	// ==============================
	// Pixel register stage
	// ==============================
	always_ff @(posedge CLK) begin
		if (reset) begin
			pix_code <= '0;
			pix_bank <= '0;
			disp_d1  <= 1'b0;
		end else begin
			disp_d1 <= disp_en;               // Follows the pixel down the pipe
			if (pick_fg) begin
				pix_code <= fg_code;
				pix_bank <= fg_bank;
			end else if (pick_bg) begin
				pix_code <= bg_code;
				pix_bank <= bg_bank;
			end else begin
				// Backdrop
				pix_code <= '0;
				pix_bank <= bg_bank;
			end
		end
	end

endmodule

//--- src/palette_ctrl_regs.sv
`timescale 1ns/1ps

// Bank and layer control registers on the CPU bus
module palette_ctrl_regs #(
	parameter int BANK_BITS = 4
) (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 reg_cs_n,
	input  logic                 cpu_rw,      // 1 means write
	input  logic [1:0]           reg_addr,
	input  logic [7:0]           cpu_din,
	output logic [7:0]           reg_dout,
	output logic [BANK_BITS-1:0] fg_bank,
	output logic [BANK_BITS-1:0] bg_bank,
	output logic                 fg_en,
	output logic                 bg_en,
	output logic                 bg_prio
);

	logic [2:0] ctrl_q;                       // Layer enables and priority
	logic       reg_wr;
	logic       reg_rd;

	assign reg_wr = ~reg_cs_n & cpu_rw;
	assign reg_rd = ~reg_cs_n & ~cpu_rw;

	// ==============================
	// Register writes
	// ==============================
	always_ff @(posedge CLK) begin
		if (reset) begin
			fg_bank <= BANK_BITS'(palette_regs_pkg::FG_BANK_RST);
			bg_bank <= BANK_BITS'(palette_regs_pkg::BG_BANK_RST);
			ctrl_q  <= 3'(palette_regs_pkg::CTRL_RST);
		end else if (reg_wr) begin
			case (reg_addr)
				palette_regs_pkg::REG_FG_BANK: fg_bank <= cpu_din[BANK_BITS-1:0];  // Upper bits dropped
				palette_regs_pkg::REG_BG_BANK: bg_bank <= cpu_din[BANK_BITS-1:0];
				palette_regs_pkg::REG_CTRL:    ctrl_q  <= cpu_din[2:0];
				default: ;                      // Offset 3 unused
			endcase
		end
	end

	// Decoded control bits
	assign fg_en   = ctrl_q[palette_regs_pkg::CTRL_FG_EN];
	assign bg_en   = ctrl_q[palette_regs_pkg::CTRL_BG_EN];
	assign bg_prio = ctrl_q[palette_regs_pkg::CTRL_BG_PRIO];

	// ==============================
	// Read back
	// ==============================
	always_comb begin
		reg_dout = 8'hFF;                     // Idle bus level
		if (reg_rd) begin
			case (reg_addr)
				palette_regs_pkg::REG_FG_BANK: reg_dout = 8'(fg_bank);
				palette_regs_pkg::REG_BG_BANK: reg_dout = 8'(bg_bank);
				palette_regs_pkg::REG_CTRL:    reg_dout = 8'(ctrl_q);
				default:                       reg_dout = 8'h00;
			endcase
		end
	end

endmodule

//--- src/palette_dac_top.sv
`timescale 1ns/1ps

// Colour output stage built from registers, mixer and palette DAC
module palette_dac_top #(
	parameter int CODE_BITS = palette_pkg::CODE_BITS_DEF,
	parameter int BANK_BITS = palette_pkg::BANK_BITS_DEF
) (
	input  logic                            CLK,
	input  logic                            reset,
	// CPU bus
	input  logic [BANK_BITS+7:0]            cpu_addr,
	input  logic [7:0]                      cpu_din,
	output logic [7:0]                      cpu_dout,
	input  logic                            cpu_rw,
	input  logic                            pal_cs_n,
	input  logic                            pal_wr_n,
	input  logic                            reg_cs_n,
	// Layer pixels
	input  logic [CODE_BITS-1:0]            fg_code,
	input  logic [CODE_BITS-1:0]            bg_code,
	input  logic                            disp_en,
	// Video out
	output logic [palette_pkg::COLOR_W-1:0] red,
	output logic [palette_pkg::COLOR_W-1:0] green,
	output logic [palette_pkg::COLOR_W-1:0] blue
);

	logic [7:0]           reg_dout;
	logic [7:0]           pal_dout;
	logic [BANK_BITS-1:0] fg_bank;
	logic [BANK_BITS-1:0] bg_bank;
	logic                 fg_en;
	logic                 bg_en;
	logic                 bg_prio;
	logic [CODE_BITS-1:0] pix_code;
	logic [BANK_BITS-1:0] pix_bank;
	logic                 disp_d1;

	palette_ctrl_regs #(.BANK_BITS(BANK_BITS)) i_palette_ctrl_regs (
		.CLK      (CLK),
		.reset    (reset),
		.reg_cs_n (reg_cs_n),
		.cpu_rw   (cpu_rw),
		.reg_addr (cpu_addr[1:0]),
		.cpu_din  (cpu_din),
		.reg_dout (reg_dout),
		.fg_bank  (fg_bank),
		.bg_bank  (bg_bank),
		.fg_en    (fg_en),
		.bg_en    (bg_en),
		.bg_prio  (bg_prio)
	);

	layer_mixer #(.CODE_BITS(CODE_BITS), .BANK_BITS(BANK_BITS)) i_layer_mixer (
		.CLK      (CLK),
		.reset    (reset),
		.fg_code  (fg_code),
		.bg_code  (bg_code),
		.disp_en  (disp_en),
		.fg_bank  (fg_bank),
		.bg_bank  (bg_bank),
		.fg_en    (fg_en),
		.bg_en    (bg_en),
		.bg_prio  (bg_prio),
		.pix_code (pix_code),
		.pix_bank (pix_bank),
		.disp_d1  (disp_d1)
	);

	color_palette_dac #(.CODE_BITS(CODE_BITS), .BANK_BITS(BANK_BITS)) i_color_palette_dac (
		.CLK      (CLK),
		.reset    (reset),
		.pix_code (pix_code),
		.pix_bank (pix_bank),
		.disp_d1  (disp_d1),
		.disp_en  (disp_en),
		.cpu_addr (cpu_addr),
		.cpu_din  (cpu_din),
		.cpu_rw   (cpu_rw),
		.pal_cs_n (pal_cs_n),
		.pal_wr_n (pal_wr_n),
		.pal_dout (pal_dout),
		.red      (red),
		.green    (green),
		.blue     (blue)
	);

	// Register block has the bus when selected
	assign cpu_dout = ~reg_cs_n ? reg_dout : pal_dout;

endmodule

//--- src/palette_pkg.sv
// ==============================
// Palette word format
// ==============================
package palette_pkg;

	// Width of each DAC colour channel
	localparam int COLOR_W = 5;

	// Default pixel path geometry
	localparam int CODE_BITS_DEF = 7;     // Colour code from the layer generators
	localparam int BANK_BITS_DEF = 4;     // Palette bank from the CPU registers

	// One 16-bit palette entry
	// The CPU sees two bytes and the DAC sees packed RGB555 with green split
	// across both bytes (low green bits sit on top of the high byte)
	typedef union packed {
		struct packed {
			logic [7:0] hi;               // Written with A0 low
			logic [7:0] lo;               // Written with A0 high
		} bytes;
		struct packed {
			logic [2:0] g_lo;             // Green 2..0
			logic [4:0] r;                // Red
			logic       spare;            // Not wired to the DAC
			logic [4:0] b;                // Blue
			logic [1:0] g_hi;             // Green 4..3
		} color;
	} palette_entry_u;

endpackage

//--- src/palette_ram.sv
`timescale 1ns/1ps

// Byte wide palette storage, one port shared by CPU and video
module palette_ram #(
	parameter int ADDR_W = 11
) (
	input  logic              CLK,
	input  logic [ADDR_W-1:0] addr,
	input  logic [7:0]        data,
	input  logic              we,
	output logic [7:0]        q
);

	logic [7:0] mem [0:(1 << ADDR_W) - 1];    // One byte of each palette word

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= data;
			q         <= data;              // Write first
		end else begin
			q <= mem[addr];                 // Registered read
		end
	end

endmodule

//--- src/palette_regs_pkg.sv
// ==============================
// CPU register map
// ==============================
package palette_regs_pkg;

	// Register offsets on cpu_addr[1:0]
	localparam logic [1:0] REG_FG_BANK = 2'd0;
	localparam logic [1:0] REG_BG_BANK = 2'd1;
	localparam logic [1:0] REG_CTRL    = 2'd2;

	// Control register bit positions
	localparam int CTRL_FG_EN   = 0;      // Foreground layer visible
	localparam int CTRL_BG_EN   = 1;      // Background layer visible
	localparam int CTRL_BG_PRIO = 2;      // Background drawn over foreground

	// Reset values
	localparam logic [7:0] FG_BANK_RST = 8'h00;
	localparam logic [7:0] BG_BANK_RST = 8'h01;
	localparam logic [7:0] CTRL_RST    = 8'h03;  // Both layers on, foreground on top

endpackage

//--- testbench/palette_dac_properties.sv
`timescale 1ns/1ps

// Checks bound into the colour output stage
module palette_dac_properties (
	input logic                            CLK,
	input logic                            reset,
	input logic                            disp_en,
	input logic                            pal_cs_n,
	input logic                            reg_cs_n,
	input logic [7:0]                      cpu_dout,
	input logic [palette_pkg::COLOR_W-1:0] red,
	input logic [palette_pkg::COLOR_W-1:0] green,
	input logic [palette_pkg::COLOR_W-1:0] blue
);

	logic rgb_black;

	assign rgb_black = (red == '0) && (green == '0) && (blue == '0);

	// ==============================
	// Video output
	// ==============================
	// Three stage pipe from disp_en to RGB
	blank_follows_disp: assert property (@(posedge CLK) disable iff (reset)
		!$past(disp_en, 3) |-> rgb_black)
		else $error("RGB not black three cycles after display was off");

	black_after_reset: assert property (@(posedge CLK) $fell(reset) |-> rgb_black)
		else $error("RGB not black right after reset");

	// Idle CPU bus
	open_bus_ones: assert property (@(posedge CLK) (pal_cs_n && reg_cs_n) |-> (cpu_dout == 8'hFF))
		else $error("cpu_dout not all ones with no select active");

endmodule

bind palette_dac_top palette_dac_properties i_palette_dac_properties (
	.CLK      (CLK),
	.reset    (reset),
	.disp_en  (disp_en),
	.pal_cs_n (pal_cs_n),
	.reg_cs_n (reg_cs_n),
	.cpu_dout (cpu_dout),
	.red      (red),
	.green    (green),
	.blue     (blue)
);

//--- testbench/tb_palette_dac_top.sv
`timescale 1ns/1ps

module tb_palette_dac_top;

	localparam int CODE_BITS    = palette_pkg::CODE_BITS_DEF;
	localparam int BANK_BITS    = palette_pkg::BANK_BITS_DEF;
	localparam int CPU_AW       = BANK_BITS + 8;
	localparam int PAL_AW       = CODE_BITS + BANK_BITS;
	localparam int PAL_WORDS    = 1 << PAL_AW;
	localparam int RGB_W        = 3 * palette_pkg::COLOR_W;
	localparam int PERIOD       = 8;
	localparam int RESET_CYCLES = 16;
	localparam int CASE_AW      = 4;
	localparam int NUM_CASES    = 16;
	localparam int LOAD_CYCLES  = RESET_CYCLES + 2 * PAL_WORDS + 100;    // Reset, load, bus tests
	localparam int TIMEOUT_NS   = (LOAD_CYCLES + NUM_CASES * 20) * PERIOD;
	localparam logic [7:0] BANK_MASK = 8'((1 << BANK_BITS) - 1);

	// ==============================
	// Pixel cases
	// ==============================
	// [23:16] fg code  [15:8] bg code  [7:4] control  [0] display enable
	localparam logic [23:0] CASE_TABLE [0:NUM_CASES-1] = '{
		{8'h05, 8'h03, 4'h1, 4'h1},   // Foreground only
		{8'h1F, 8'h00, 4'h1, 4'h1},
		{8'h7A, 8'h11, 4'h1, 4'h1},
		{8'h20, 8'h07, 4'h1, 4'h1},   // Transparent pen, bg off, so backdrop
		{8'h13, 8'h24, 4'h3, 4'h1},   // Both opaque, fg on top
		{8'h13, 8'h24, 4'h7, 4'h1},   // Both opaque, bg on top
		{8'h10, 8'h24, 4'h3, 4'h1},   // Fg transparent
		{8'h13, 8'h30, 4'h7, 4'h1},   // Bg transparent despite priority
		{8'h40, 8'h50, 4'h7, 4'h1},   // Backdrop
		{8'h0E, 8'h6B, 4'h2, 4'h1},   // Bg layer only
		{8'h0E, 8'h6B, 4'h0, 4'h1},   // Both layers off
		{8'h0E, 8'h6B, 4'h4, 4'h1},
		{8'h13, 8'h24, 4'h3, 4'h0},   // Blanked
		{8'h7F, 8'h7F, 4'h7, 4'h0},
		{8'h7F, 8'h7F, 4'h7, 4'h1},   // Display back on
		{8'h01, 8'h00, 4'h1, 4'h1}
	};

	logic                            CLK;
	logic                            reset;
	logic [CPU_AW-1:0]               cpu_addr;
	logic [7:0]                      cpu_din;
	logic [7:0]                      cpu_dout;
	logic                            cpu_rw;
	logic                            pal_cs_n;
	logic                            pal_wr_n;
	logic                            reg_cs_n;
	logic [CODE_BITS-1:0]            fg_code;
	logic [CODE_BITS-1:0]            bg_code;
	logic                            disp_en;
	logic [palette_pkg::COLOR_W-1:0] red;
	logic [palette_pkg::COLOR_W-1:0] green;
	logic [palette_pkg::COLOR_W-1:0] blue;

	palette_pkg::palette_entry_u shadow [0:PAL_WORDS-1];   // Model of both byte RAMs
	int                   seed;
	int                   errors;
	int                   checks;
	int                   tests_run;
	int                   test_errors;      // Error count when the current test began
	logic [BANK_BITS-1:0] fg_bank_val;      // Bank register values as written
	logic [BANK_BITS-1:0] bg_bank_val;
	logic [RGB_W-1:0]     prev_rgb;         // Output still expected before the new pixel

	palette_dac_top #(.CODE_BITS(CODE_BITS), .BANK_BITS(BANK_BITS)) i_palette_dac_top (
		.CLK      (CLK),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_din  (cpu_din),
		.cpu_dout (cpu_dout),
		.cpu_rw   (cpu_rw),
		.pal_cs_n (pal_cs_n),
		.pal_wr_n (pal_wr_n),
		.reg_cs_n (reg_cs_n),
		.fg_code  (fg_code),
		.bg_code  (bg_code),
		.disp_en  (disp_en),
		.red      (red),
		.green    (green),
		.blue     (blue)
	);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired at %0t, the run did not reach its end", $time);
		$display("tests failed");
		$finish;
	end

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_errors)
			$display("test %0d %s: ok", tests_run, name);
		else
			$display("test %0d %s: %0d mismatches", tests_run, name, errors - test_errors);
		test_errors = errors;
	endtask

	// ==============================
	// CPU bus cycles
	// ==============================
	// Each one starts and ends 1 ns after a rising edge
	task automatic reg_write(input logic [1:0] offs, input logic [7:0] val);
		cpu_addr = CPU_AW'(offs);
		cpu_din  = val;
		cpu_rw   = 1'b1;
		reg_cs_n = 1'b0;
		@(posedge CLK);
		#1;
		reg_cs_n = 1'b1;
		cpu_rw   = 1'b0;
	endtask

	task automatic reg_read_check(input logic [1:0] offs, input logic [7:0] exp, input string what);
		cpu_addr = CPU_AW'(offs);
		reg_cs_n = 1'b0;                      // cpu_rw idles low
		@(posedge CLK);
		#1;
		check_value(what, 32'(cpu_dout), 32'(exp));
		reg_cs_n = 1'b1;
	endtask

	task automatic pal_write(input logic [PAL_AW-1:0] word, input logic a0, input logic [7:0] val);
		cpu_addr = {word, a0};
		cpu_din  = val;
		cpu_rw   = 1'b1;
		pal_cs_n = 1'b0;
		pal_wr_n = 1'b0;
		@(posedge CLK);
		#1;
		pal_cs_n = 1'b1;
		pal_wr_n = 1'b1;
		cpu_rw   = 1'b0;
	endtask

	task automatic pal_read_check(input logic [PAL_AW-1:0] word, input logic a0,
	                              input logic [7:0] exp, input string what);
		cpu_addr = {word, a0};
		pal_cs_n = 1'b0;
		@(posedge CLK);                       // Data one cycle after the address
		#1;
		check_value(what, 32'(cpu_dout), 32'(exp));
		pal_cs_n = 1'b1;
	endtask

	// ==============================
	// Video model
	// ==============================
	function automatic logic [RGB_W-1:0] expected_rgb(input logic [23:0] row);
		logic [CODE_BITS-1:0]        fg;
		logic [CODE_BITS-1:0]        bg;
		logic [3:0]                  ctrl;
		logic                        fg_op;
		logic                        bg_op;
		logic [PAL_AW-1:0]           addr;
		palette_pkg::palette_entry_u word;
		fg   = row[16 +: CODE_BITS];
		bg   = row[8 +: CODE_BITS];
		ctrl = row[7:4];
		if (!row[0])
			return '0;                        // Black outside active video
		// Opaque means enabled with a non-zero pen
		fg_op = ctrl[palette_regs_pkg::CTRL_FG_EN] && (fg[3:0] != 4'h0);
		bg_op = ctrl[palette_regs_pkg::CTRL_BG_EN] && (bg[3:0] != 4'h0);
		if (fg_op && bg_op)
			addr = ctrl[palette_regs_pkg::CTRL_BG_PRIO] ? {bg_bank_val, bg} : {fg_bank_val, fg};
		else if (fg_op)
			addr = {fg_bank_val, fg};
		else if (bg_op)
			addr = {bg_bank_val, bg};
		else
			addr = {bg_bank_val, {CODE_BITS{1'b0}}};  // Backdrop
		word = shadow[addr];
		return {word.color.r, word.color.g_hi, word.color.g_lo, word.color.b};
	endfunction

	task automatic run_cases(input int first, input int last);
		logic [CASE_AW-1:0] ci;
		logic [23:0]        row;
		logic [RGB_W-1:0]   exp;
		int                 i;
		for (i = first; i <= last; i++) begin
			ci  = CASE_AW'(i);
			row = CASE_TABLE[ci];
			reg_write(palette_regs_pkg::REG_CTRL, {4'h0, row[7:4]});
			fg_code = row[16 +: CODE_BITS];   // Held for the whole case
			bg_code = row[8 +: CODE_BITS];
			disp_en = row[0];
			exp     = expected_rgb(row);
			@(posedge CLK);
			@(posedge CLK);
			#1;
			if (row[0])                       // Two edges in, the old pixel is still out
				check_value($sformatf("case %0d early", i), 32'({red, green, blue}), 32'(prev_rgb));
			@(posedge CLK);
			#1;
			check_value($sformatf("case %0d rgb", i), 32'({red, green, blue}), 32'(exp));
			prev_rgb = exp;
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		logic [PAL_AW-1:0] w;
		logic [PAL_AW-1:0] prot;
		int                k;
		seed        = 32'h8496;
		errors      = 0;
		checks      = 0;
		tests_run   = 0;
		test_errors = 0;
		prev_rgb    = '0;
		fg_bank_val = '0;
		bg_bank_val = '0;
		cpu_addr    = '0;
		cpu_din     = '0;
		cpu_rw      = 1'b0;
		pal_cs_n    = 1'b1;
		pal_wr_n    = 1'b1;
		reg_cs_n    = 1'b1;
		fg_code     = '0;
		bg_code     = '0;
		disp_en     = 1'b0;
		reset       = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		reset = 1'b0;

		// Reset values, then write and read back with bank truncation
		reg_read_check(palette_regs_pkg::REG_FG_BANK, palette_regs_pkg::FG_BANK_RST & BANK_MASK,
		               "fg bank reset");
		reg_read_check(palette_regs_pkg::REG_BG_BANK, palette_regs_pkg::BG_BANK_RST & BANK_MASK,
		               "bg bank reset");
		reg_read_check(palette_regs_pkg::REG_CTRL, palette_regs_pkg::CTRL_RST, "ctrl reset");
		reg_write(palette_regs_pkg::REG_FG_BANK, 8'hF5);
		reg_write(palette_regs_pkg::REG_BG_BANK, 8'h3A);
		reg_write(palette_regs_pkg::REG_CTRL, 8'h05);
		fg_bank_val = BANK_BITS'(8'hF5);
		bg_bank_val = BANK_BITS'(8'h3A);
		reg_read_check(palette_regs_pkg::REG_FG_BANK, 8'hF5 & BANK_MASK, "fg bank write");
		reg_read_check(palette_regs_pkg::REG_BG_BANK, 8'h3A & BANK_MASK, "bg bank write");
		reg_read_check(palette_regs_pkg::REG_CTRL, 8'h05, "ctrl write");
		finish_test("registers");

		// Fill the whole palette during blanking
		for (k = 0; k < PAL_WORDS; k++) begin
			w         = PAL_AW'(k);
			shadow[w] = 16'($random(seed));
			pal_write(w, 1'b0, shadow[w].bytes.hi);   // A0 low is the high byte
			pal_write(w, 1'b1, shadow[w].bytes.lo);
		end
		for (k = 0; k < 8; k++) begin
			w = PAL_AW'(k * 263);             // Spread over banks
			pal_read_check(w, 1'b0, shadow[w].bytes.hi, "palette high byte");
			pal_read_check(w, 1'b1, shadow[w].bytes.lo, "palette low byte");
		end
		cpu_addr = CPU_AW'(12'h2A5);          // Nothing selected
		@(posedge CLK);
		#1;
		check_value("open bus", 32'(cpu_dout), 32'hFF);
		finish_test("palette bus");

		run_cases(0, 3);
		finish_test("foreground");
		run_cases(4, 11);
		finish_test("mixing");

		// Blanking, then writes during display must be dropped
		run_cases(12, 15);
		prot    = {fg_bank_val, CODE_BITS'(7'h13)};
		disp_en = 1'b1;
		pal_write(prot, 1'b0, ~shadow[prot].bytes.hi);
		pal_write(prot, 1'b1, ~shadow[prot].bytes.lo);
		cpu_addr = {prot, 1'b0};
		pal_cs_n = 1'b0;
		@(posedge CLK);
		#1;
		check_value("palette read in display", 32'(cpu_dout), 32'hFF);
		pal_cs_n = 1'b1;
		disp_en  = 1'b0;
		pal_read_check(prot, 1'b0, shadow[prot].bytes.hi, "protected high byte");
		pal_read_check(prot, 1'b1, shadow[prot].bytes.lo, "protected low byte");
		finish_test("blanking");

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
